// File: hdl/cpu_defs.svh
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

////////////////////
// widths

`define WORD_SIZE     16
`define REG_ADDR_SIZE 2
`define NUM_REGS      4
`define IMM_SIZE      8

////////////////////
// instruction fields

`define OPCODE 15:12
`define RS     11:10
`define RT     9:8
`define RD     7:6
`define FUNC   5:0

`endif

// File: hdl/cpu_pkg.sv
`include "cpu_defs.svh"

package cpu_pkg;

    typedef enum logic [3:0] {
        OPC_ADI    = 4'd4,
        OPC_ORI    = 4'd5,
        OPC_LHI    = 4'd6,
        OPC_R_TYPE = 4'd15
    } opcode_e;

    // r-type func field
    typedef enum logic [5:0] {
        FN_ADD = 6'd0,
        FN_SUB = 6'd1,
        FN_AND = 6'd2,
        FN_ORR = 6'd3,
        FN_NOT = 6'd4,
        FN_TCP = 6'd5,
        FN_SHL = 6'd6,
        FN_SHR = 6'd7,
        FN_WWD = 6'd28,
        FN_HLT = 6'd29
    } func_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_NOT,
        ALU_TCP,    // two's complement
        ALU_SHL,
        ALU_SHR,
        ALU_LHI
    } alu_op_e;

    typedef struct packed {
        logic                      valid;
        alu_op_e                   alu_op;
        logic                      alu_src;      // b from immediate
        logic                      imm_zero_ext;
        logic                      reg_write;
        logic [`REG_ADDR_SIZE-1:0] dest;
        logic [`REG_ADDR_SIZE-1:0] rs;
        logic [`REG_ADDR_SIZE-1:0] rt;
        logic                      wwd;
        logic                      halt;
        logic [`IMM_SIZE-1:0]      imm;
    } ctrl_t;

    typedef struct packed {
        logic                      valid;
        logic                      reg_write;
        logic [`REG_ADDR_SIZE-1:0] dest;
        logic                      wwd;
        logic                      halt;
        logic [`WORD_SIZE-1:0]     result;
    } ex_wb_t;

endpackage

// File: hdl/decode_unit.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module decode_unit
    import cpu_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  inst_valid,
    input  logic [`WORD_SIZE-1:0] inst,
    output ctrl_t                 id_ctrl
);

    logic halt_seen;
    logic known;

    ////////////////////
    // decode

    always_comb begin
        id_ctrl     = '0;
        known       = 1'b1;
        id_ctrl.rs  = inst[`RS];
        id_ctrl.rt  = inst[`RT];
        id_ctrl.imm = inst[`IMM_SIZE-1:0];

        case (inst[`OPCODE])
            OPC_R_TYPE: begin
                id_ctrl.reg_write = 1'b1;
                id_ctrl.dest      = inst[`RD];
                case (inst[`FUNC])
                    FN_ADD: id_ctrl.alu_op = ALU_ADD;
                    FN_SUB: id_ctrl.alu_op = ALU_SUB;
                    FN_AND: id_ctrl.alu_op = ALU_AND;
                    FN_ORR: id_ctrl.alu_op = ALU_OR;
                    FN_NOT: id_ctrl.alu_op = ALU_NOT;
                    FN_TCP: id_ctrl.alu_op = ALU_TCP;
                    FN_SHL: id_ctrl.alu_op = ALU_SHL;
                    FN_SHR: id_ctrl.alu_op = ALU_SHR;
                    FN_WWD: begin
                        id_ctrl.wwd       = 1'b1;
                        id_ctrl.reg_write = 1'b0;
                    end
                    FN_HLT: begin
                        id_ctrl.halt      = 1'b1;
                        id_ctrl.reg_write = 1'b0;
                    end
                    default: known = 1'b0;
                endcase
            end
            OPC_ADI: begin
                id_ctrl.alu_op    = ALU_ADD;
                id_ctrl.alu_src   = 1'b1;   // sign extended
                id_ctrl.reg_write = 1'b1;
                id_ctrl.dest      = inst[`RT];
            end
            OPC_ORI: begin
                id_ctrl.alu_op       = ALU_OR;
                id_ctrl.alu_src      = 1'b1;
                id_ctrl.imm_zero_ext = 1'b1;
                id_ctrl.reg_write    = 1'b1;
                id_ctrl.dest         = inst[`RT];
            end
            OPC_LHI: begin
                id_ctrl.alu_op    = ALU_LHI;
                id_ctrl.alu_src   = 1'b1;
                id_ctrl.reg_write = 1'b1;
                id_ctrl.dest      = inst[`RT];
            end
            default: known = 1'b0;
        endcase

        id_ctrl.valid = inst_valid && known && !halt_seen;
    end

    // everything after an accepted HLT is dropped
    always_ff @(posedge clk) begin
        if (reset_n) begin
            halt_seen <= 1'b0;
        end else if (id_ctrl.valid && id_ctrl.halt) begin
            halt_seen <= 1'b1;
        end
    end

    a_no_issue_after_halt: assert property (
        @(posedge clk) disable iff (reset_n)
        id_ctrl.valid && id_ctrl.halt |=> !id_ctrl.valid
    );

endmodule

// File: hdl/register_file.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module register_file
    import cpu_pkg::*;
(
    input  logic                      clk,
    input  logic                      reset_n,
    input  logic [`REG_ADDR_SIZE-1:0] read1,
    input  logic [`REG_ADDR_SIZE-1:0] read2,
    input  ex_wb_t                    wb,
    output logic [`WORD_SIZE-1:0]     read_out1,
    output logic [`WORD_SIZE-1:0]     read_out2
);

    logic [`WORD_SIZE-1:0] regs [`NUM_REGS];
    logic                  write_en;

    assign write_en = wb.valid && wb.reg_write;

    always_ff @(posedge clk) begin
        if (reset_n) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (write_en) begin
            regs[wb.dest] <= wb.result;
        end
    end

    // write-through so a read in the write cycle sees new data
    always_comb begin
        read_out1 = regs[read1];
        read_out2 = regs[read2];
        if (write_en && wb.dest == read1) begin
            read_out1 = wb.result;
        end
        if (write_en && wb.dest == read2) begin
            read_out2 = wb.result;
        end
    end

    // wb comes out of reset one edge into reset
    a_no_write_in_reset: assert property (
        @(posedge clk)
        reset_n && $past(reset_n) |-> !write_en
    );

endmodule

// File: hdl/execute_stage.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module execute_stage
    import cpu_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset_n,
    input  ctrl_t                 id_ctrl,
    input  logic [`WORD_SIZE-1:0] read_data_1,
    input  logic [`WORD_SIZE-1:0] read_data_2,
    output ex_wb_t                wb,
    output logic [`WORD_SIZE-1:0] output_port,
    output logic [`WORD_SIZE-1:0] num_inst,
    output logic                  is_halted
);

    ctrl_t                 id_ex;
    logic [`WORD_SIZE-1:0] op_a_q;
    logic [`WORD_SIZE-1:0] op_b_q;
    logic                  wb_writes;
    logic [`WORD_SIZE-1:0] op_a;
    logic [`WORD_SIZE-1:0] op_b_reg;
    logic [`WORD_SIZE-1:0] imm_ext;
    logic [`WORD_SIZE-1:0] op_b;
    logic [`WORD_SIZE-1:0] alu_out;

    ////////////////////
    // id/ex

    always_ff @(posedge clk) begin
        if (reset_n) begin
            id_ex <= '0;
        end else begin
            id_ex <= id_ctrl;
        end
    end

    always_ff @(posedge clk) begin
        op_a_q <= read_data_1;
        op_b_q <= read_data_2;
    end

    ////////////////////
    // forwarding + alu

    assign wb_writes = wb.valid && wb.reg_write;

    // distance one, older results come through the regfile
    assign op_a     = (wb_writes && wb.dest == id_ex.rs) ? wb.result : op_a_q;
    assign op_b_reg = (wb_writes && wb.dest == id_ex.rt) ? wb.result : op_b_q;

    always_comb begin
        if (id_ex.imm_zero_ext) begin
            imm_ext = {{(`WORD_SIZE-`IMM_SIZE){1'b0}}, id_ex.imm};
        end else begin
            imm_ext = {{(`WORD_SIZE-`IMM_SIZE){id_ex.imm[`IMM_SIZE-1]}}, id_ex.imm};
        end
    end

    assign op_b = id_ex.alu_src ? imm_ext : op_b_reg;

    always_comb begin
        case (id_ex.alu_op)
            ALU_ADD: alu_out = op_a + op_b;     // overflow dropped
            ALU_SUB: alu_out = op_a - op_b;
            ALU_AND: alu_out = op_a & op_b;
            ALU_OR:  alu_out = op_a | op_b;
            ALU_NOT: alu_out = ~op_a;
            ALU_TCP: alu_out = ~op_a + `WORD_SIZE'd1;
            ALU_SHL: alu_out = op_a << 1;
            ALU_SHR: alu_out = $signed(op_a) >>> 1;   // arithmetic
            ALU_LHI: alu_out = {id_ex.imm, {(`WORD_SIZE-`IMM_SIZE){1'b0}}};
            default: alu_out = '0;
        endcase
    end

    ////////////////////
    // ex/wb

    always_ff @(posedge clk) begin
        if (reset_n) begin
            wb <= '0;
        end else begin
            wb.valid     <= id_ex.valid;
            wb.reg_write <= id_ex.valid && id_ex.reg_write;
            wb.dest      <= id_ex.dest;
            wb.wwd       <= id_ex.wwd;
            wb.halt      <= id_ex.halt;
            wb.result    <= id_ex.wwd ? op_a : alu_out;
        end
    end

    // retire
    always_ff @(posedge clk) begin
        if (reset_n) begin
            output_port <= '0;
            num_inst    <= '0;
            is_halted   <= 1'b0;
        end else if (wb.valid) begin
            num_inst <= num_inst + `WORD_SIZE'd1;
            if (wb.wwd) begin
                output_port <= wb.result;
            end
            if (wb.halt) begin
                is_halted <= 1'b1;
            end
        end
    end

    // port frozen once halted
    a_port_only_on_wwd: assert property (
        @(posedge clk) disable iff (reset_n)
        $changed(output_port) |-> !$past(is_halted)
    );

endmodule

// File: hdl/cpu.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpu
    import cpu_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  inst_valid,
    input  logic [`WORD_SIZE-1:0] inst,
    output logic [`WORD_SIZE-1:0] output_port,
    output logic [`WORD_SIZE-1:0] num_inst,
    output logic                  is_halted
);

    ctrl_t                 id_ctrl;
    ex_wb_t                wb;
    logic [`WORD_SIZE-1:0] read_data_1;
    logic [`WORD_SIZE-1:0] read_data_2;

    decode_unit u_decode (
        .clk        (clk),
        .reset_n    (reset_n),
        .inst_valid (inst_valid),
        .inst       (inst),
        .id_ctrl    (id_ctrl)
    );

    // read side by side with decode
    register_file u_regs (
        .clk       (clk),
        .reset_n   (reset_n),
        .read1     (id_ctrl.rs),
        .read2     (id_ctrl.rt),
        .wb        (wb),
        .read_out1 (read_data_1),
        .read_out2 (read_data_2)
    );

    execute_stage u_execute (
        .clk         (clk),
        .reset_n     (reset_n),
        .id_ctrl     (id_ctrl),
        .read_data_1 (read_data_1),
        .read_data_2 (read_data_2),
        .wb          (wb),
        .output_port (output_port),
        .num_inst    (num_inst),
        .is_halted   (is_halted)
    );

endmodule

// File: tests/cpu_tb.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpu_tb;

    localparam int CLK_PERIOD = 20;
    localparam int NUM_STEPS  = 36;
    localparam int LATENCY    = 3;    // falling edges from drive to settled outputs

    localparam logic [3:0] OP_ADI = 4'd4;
    localparam logic [3:0] OP_ORI = 4'd5;
    localparam logic [3:0] OP_LHI = 4'd6;
    localparam logic [3:0] OP_R   = 4'd15;

    localparam logic [5:0] F_ADD = 6'd0;
    localparam logic [5:0] F_SUB = 6'd1;
    localparam logic [5:0] F_AND = 6'd2;
    localparam logic [5:0] F_ORR = 6'd3;
    localparam logic [5:0] F_NOT = 6'd4;
    localparam logic [5:0] F_TCP = 6'd5;
    localparam logic [5:0] F_SHL = 6'd6;
    localparam logic [5:0] F_SHR = 6'd7;
    localparam logic [5:0] F_WWD = 6'd28;
    localparam logic [5:0] F_HLT = 6'd29;

    typedef struct packed {
        logic                  valid;
        logic [`WORD_SIZE-1:0] inst;
        logic                  check;
        logic [`WORD_SIZE-1:0] exp_port;
        logic [`WORD_SIZE-1:0] exp_num;
        logic                  exp_halted;
    } step_t;

    logic                  clk;
    logic                  reset_n;
    logic                  inst_valid;
    logic [`WORD_SIZE-1:0] inst;
    logic [`WORD_SIZE-1:0] output_port;
    logic [`WORD_SIZE-1:0] num_inst;
    logic                  is_halted;

    step_t steps [NUM_STEPS];
    int    n_steps;

    cpu uut (
        .clk         (clk),
        .reset_n     (reset_n),
        .inst_valid  (inst_valid),
        .inst        (inst),
        .output_port (output_port),
        .num_inst    (num_inst),
        .is_halted   (is_halted)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [15:0] r_type(input logic [5:0] func, input logic [1:0] rs,
                                           input logic [1:0] rt, input logic [1:0] rd);
        return {OP_R, rs, rt, rd, func};
    endfunction

    function automatic logic [15:0] i_type(input logic [3:0] op, input logic [1:0] rs,
                                           input logic [1:0] rt, input logic [7:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic add_step(input logic valid, input logic [15:0] word, input logic check,
                            input logic [15:0] port, input logic [15:0] num,
                            input logic halted);
        steps[n_steps] = '{valid, word, check, port, num, halted};
        n_steps++;
    endtask

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic compare_outputs(input int idx);
        step_t s;
        s = steps[idx];
        assert (output_port === s.exp_port) else
            report_failure($sformatf("** Error: step %0d output_port = %h, expected %h",
                                     idx, output_port, s.exp_port));
        assert (num_inst === s.exp_num) else
            report_failure($sformatf("** Error: step %0d num_inst = %h, expected %h",
                                     idx, num_inst, s.exp_num));
        assert (is_halted === s.exp_halted) else
            report_failure($sformatf("** Error: step %0d is_halted = %h, expected %h",
                                     idx, is_halted, s.exp_halted));
    endtask

    ////////////////////
    // stimulus table

    task automatic build_table();
        add_step(0, '0, 1, 16'h0000, 16'd0, 0);                      // after reset
        add_step(1, i_type(OP_ADI, 0, 1, 8'h05), 0, 0, 0, 0);        // r1 = 5
        add_step(1, i_type(OP_ADI, 0, 2, 8'h03), 0, 0, 0, 0);        // r2 = 3
        add_step(1, r_type(F_ADD, 1, 2, 3), 0, 0, 0, 0);             // r3 = 8
        add_step(1, r_type(F_WWD, 3, 0, 0), 1, 16'h0008, 16'd4, 0);
        add_step(1, r_type(F_SUB, 3, 1, 3), 0, 0, 0, 0);             // 8 - 5
        add_step(1, r_type(F_WWD, 3, 0, 0), 1, 16'h0003, 16'd6, 0);
        add_step(1, r_type(F_AND, 3, 1, 3), 0, 0, 0, 0);
        add_step(1, r_type(F_WWD, 3, 0, 0), 1, 16'h0001, 16'd8, 0);
        add_step(1, r_type(F_ORR, 3, 1, 3), 0, 0, 0, 0);
        add_step(1, r_type(F_WWD, 3, 0, 0), 1, 16'h0005, 16'd10, 0);
        add_step(1, r_type(F_NOT, 3, 0, 3), 0, 0, 0, 0);
        add_step(1, r_type(F_WWD, 3, 0, 0), 1, 16'hFFFA, 16'd12, 0);
        add_step(1, r_type(F_TCP, 3, 0, 3), 0, 0, 0, 0);             // negate
        add_step(1, r_type(F_WWD, 3, 0, 0), 1, 16'h0006, 16'd14, 0);
        add_step(1, r_type(F_SHL, 3, 0, 3), 0, 0, 0, 0);
        add_step(1, r_type(F_WWD, 3, 0, 0), 1, 16'h000C, 16'd16, 0);
        add_step(1, r_type(F_SHR, 3, 0, 3), 0, 0, 0, 0);
        add_step(1, r_type(F_WWD, 3, 0, 0), 1, 16'h0006, 16'd18, 0);
        // distance two, goes through the regfile bypass
        add_step(1, i_type(OP_ADI, 1, 1, 8'hFD), 0, 0, 0, 0);        // r1 = 5 - 3
        add_step(1, i_type(OP_ADI, 2, 2, 8'h01), 0, 0, 0, 0);        // unrelated, r2 = 4
        add_step(1, r_type(F_WWD, 1, 0, 0), 1, 16'h0002, 16'd21, 0);
        add_step(1, i_type(OP_ORI, 2, 2, 8'h80), 0, 0, 0, 0);        // zero extended
        add_step(1, r_type(F_WWD, 2, 0, 0), 1, 16'h0084, 16'd23, 0);
        add_step(1, i_type(OP_LHI, 0, 3, 8'hA5), 0, 0, 0, 0);
        add_step(1, r_type(F_WWD, 3, 0, 0), 1, 16'hA500, 16'd25, 0);
        add_step(1, i_type(OP_ADI, 0, 0, 8'h80), 0, 0, 0, 0);        // sign extended
        add_step(1, r_type(F_WWD, 0, 0, 0), 1, 16'hFF80, 16'd27, 0);
        add_step(0, r_type(F_ADD, 0, 0, 0), 0, 0, 0, 0);             // strobe low
        add_step(0, '0, 1, 16'hFF80, 16'd27, 0);
        add_step(1, r_type(F_WWD, 2, 0, 0), 1, 16'h0084, 16'd28, 0);
        add_step(1, r_type(F_HLT, 0, 0, 0), 1, 16'h0084, 16'd29, 1);
        // dropped after halt
        add_step(1, r_type(F_WWD, 3, 0, 0), 0, 0, 0, 0);
        add_step(1, i_type(OP_ADI, 0, 0, 8'h01), 0, 0, 0, 0);
        add_step(1, r_type(F_WWD, 0, 0, 0), 1, 16'h0084, 16'd29, 1);
        add_step(0, '0, 1, 16'h0084, 16'd29, 1);
    endtask

    ////////////////////
    // watchdog

    initial begin
        #((NUM_STEPS + 20) * CLK_PERIOD);
        report_failure("the run timed out before all steps were applied and checked");
    end

    initial begin
        clk        = 1'b0;
        reset_n    = 1'b1;
        inst_valid = 1'b0;
        inst       = '0;
        n_steps    = 0;
        build_table();
        if (n_steps != NUM_STEPS) begin
            report_failure("the stimulus table does not hold the expected number of steps");
        end

        repeat (3) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b0;

        for (int i = 0; i < NUM_STEPS + LATENCY; i++) begin
            @(negedge clk);
            if (i >= LATENCY) begin
                if (steps[i-LATENCY].check) begin
                    compare_outputs(i - LATENCY);
                end
            end
            if (i < NUM_STEPS) begin
                inst_valid = steps[i].valid;
                inst       = steps[i].inst;
            end else begin
                inst_valid = 1'b0;    // drain
                inst       = '0;
            end
        end

        $display("TEST OK");
        $finish;
    end

endmodule

// File: filelist.f
+incdir+hdl
hdl/cpu_pkg.sv
hdl/decode_unit.sv
hdl/register_file.sv
hdl/execute_stage.sv
hdl/cpu.sv
tests/cpu_tb.sv
